// ==== source/frontend_pkg.sv ====
// frontend package
// shared widths, register index type, operation classes and the
// RV32I major opcode constants used by the in-order front end

`default_nettype none

package frontend_pkg;

  // instruction word and address width
  parameter int xlen = 32;

  // one instruction-cache line
  parameter int line_bits = 128;

  typedef logic [4:0] reg_index_t;

  // operation class carried by each micro-operation
  typedef enum logic [3:0] {
    alu_reg = 4'd0,
    alu_imm = 4'd1,
    load    = 4'd2,
    store   = 4'd3,
    branch  = 4'd4,
    jal     = 4'd5,
    jalr    = 4'd6,
    lui     = 4'd7,
    auipc   = 4'd8,
    system  = 4'd9,
    illegal = 4'd10
  } op_class_t;

  // register-register arithmetic
  localparam logic [6:0] op_alu_reg = 7'b0110011;

  // register-immediate arithmetic
  localparam logic [6:0] op_alu_imm = 7'b0010011;

  localparam logic [6:0] op_load = 7'b0000011;

  localparam logic [6:0] op_store = 7'b0100011;

  // conditional branches
  localparam logic [6:0] op_branch = 7'b1100011;

  localparam logic [6:0] op_jal = 7'b1101111;

  localparam logic [6:0] op_jalr = 7'b1100111;

  localparam logic [6:0] op_lui = 7'b0110111;

  localparam logic [6:0] op_auipc = 7'b0010111;

  // ecall, ebreak and csr access
  localparam logic [6:0] op_system = 7'b1110011;

endpackage

`default_nettype wire

// ==== source/inst_fetch.sv ====
// instruction fetch
// walks the instruction cache one line at a time from the reset address
// and holds each returned line until the fetch buffer accepts it

`timescale 1ns/1ps
`default_nettype none

module inst_fetch #(
  parameter int                        fetch_width = 4,
  parameter logic [frontend_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                               clock,
  input  logic                               reset,
  input  logic [frontend_pkg::line_bits-1:0] icache2core_data,
  input  logic                               icache2core_data_valid,
  input  logic                               line_ready,
  output logic [frontend_pkg::xlen-1:0]      core2icache_addr,
  output logic                               line_valid,
  output logic [frontend_pkg::xlen-1:0]      line_pc,
  output logic [frontend_pkg::line_bits-1:0] line_data
);

  import frontend_pkg::*;

  localparam int line_bytes  = fetch_width * 4;
  localparam int offset_bits = $clog2(line_bytes);

  logic [xlen-1:0] fetch_pc;
  logic            capture;

  // room when the holding register is empty or drains this cycle
  assign capture = icache2core_data_valid && (!line_valid || line_ready);

  assign core2icache_addr = fetch_pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_pc   <= reset_pc;
      line_valid <= 1'b0;
    end else if (capture) begin
      fetch_pc   <= fetch_pc + xlen'(line_bytes);
      line_valid <= 1'b1;
    end else if (line_ready) begin
      line_valid <= 1'b0;
    end
  end

  // line payload
  always_ff @(posedge clock) begin
    if (capture) begin
      line_pc   <= fetch_pc;
      line_data <= icache2core_data;
    end
  end

  // fetch never leaves a line boundary
  addr_aligned: assert property (
    @(posedge clock) disable iff (reset)
    core2icache_addr[offset_bits-1:0] == '0
  ) else $error("fetch address %h not line aligned", core2icache_addr);

  // stalled line must reach the buffer unchanged
  line_held: assert property (
    @(posedge clock) disable iff (reset)
    line_valid && !line_ready |=> line_valid && $stable(line_data) && $stable(line_pc)
  ) else $error("line changed while stalled by the fetch buffer");

endmodule

`default_nettype wire

// ==== source/fetch_buffer.sv ====
// fetch buffer
// circular queue of single instructions, each with its own pc
// takes a whole cache line at once and hands out the oldest entries
// as a decode group

`timescale 1ns/1ps
`default_nettype none

module fetch_buffer #(
  parameter int fetch_width  = 4,
  parameter int decode_width = 4,
  parameter int buffer_depth = 16
) (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         line_valid,
  input  logic [frontend_pkg::xlen-1:0]                line_pc,
  input  logic [frontend_pkg::line_bits-1:0]           line_data,
  input  logic                                         group_ready,
  output logic                                         line_ready,
  output logic [decode_width-1:0]                      group_valid,
  output logic [decode_width-1:0][frontend_pkg::xlen-1:0] group_pc,
  output logic [decode_width-1:0][frontend_pkg::xlen-1:0] group_inst
);

  import frontend_pkg::*;

  localparam int ptr_bits = $clog2(buffer_depth);
  localparam int cnt_bits = $clog2(buffer_depth + 1);

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } entry_t;

  entry_t mem [buffer_depth];

  logic [ptr_bits-1:0] head;
  logic [ptr_bits-1:0] tail;
  logic [cnt_bits-1:0] count;
  logic [cnt_bits-1:0] n_out;
  logic [cnt_bits-1:0] pop_count;
  logic                push;

  // a full line needs fetch_width free slots
  assign line_ready = count <= cnt_bits'(buffer_depth - fetch_width);
  assign push       = line_valid && line_ready;

  assign n_out     = (count > cnt_bits'(decode_width)) ? cnt_bits'(decode_width) : count;
  assign pop_count = group_ready ? n_out : '0;

  // oldest entries first, slot 0 at head
  always_comb begin
    for (int i = 0; i < decode_width; i++) begin
      group_valid[i] = count > cnt_bits'(i);
      group_pc[i]    = mem[head + ptr_bits'(i)].pc;
      group_inst[i]  = mem[head + ptr_bits'(i)].inst;
    end
  end

  // each word of the line gets the line pc plus 4 per slot
  always_ff @(posedge clock) begin
    if (push) begin
      for (int i = 0; i < fetch_width; i++) begin
        mem[tail + ptr_bits'(i)] <= '{
          pc:   line_pc + xlen'(4 * i),
          inst: line_data[i * xlen +: xlen]
        };
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + ptr_bits'(pop_count);
      count <= count + (push ? cnt_bits'(fetch_width) : '0) - pop_count;
      if (push) begin
        tail <= tail + ptr_bits'(fetch_width);
      end
    end
  end

  // a refused line stays offered, so nothing is dropped between fetch and buffer
  no_lost_line: assert property (
    @(posedge clock) disable iff (reset)
    line_valid && !line_ready |=> line_valid
  ) else $error("line withdrawn before the fetch buffer took it");

  occupancy_bound: assert property (
    @(posedge clock) disable iff (reset)
    count <= cnt_bits'(buffer_depth)
  ) else $error("fetch buffer occupancy %0d above depth", count);

endmodule

`default_nettype wire

// ==== source/inst_decode.sv ====
// instruction decode
// classifies each RV32I word of the group, pulls out the register fields
// and the sign-extended immediate, and registers the micro-op group
// with a valid/ready hold on the output side

`timescale 1ns/1ps
`default_nettype none

module inst_decode #(
  parameter int decode_width = 4
) (
  input  logic                                            clock,
  input  logic                                            reset,
  input  logic [decode_width-1:0]                         group_valid,
  input  logic [decode_width-1:0][frontend_pkg::xlen-1:0] group_pc,
  input  logic [decode_width-1:0][frontend_pkg::xlen-1:0] group_inst,
  input  logic                                            uop_ready,
  output logic                                            group_ready,
  output logic [decode_width-1:0]                         uop_valid,
  output logic [decode_width-1:0][frontend_pkg::xlen-1:0] uop_pc,
  output frontend_pkg::op_class_t [decode_width-1:0]      uop_class,
  output frontend_pkg::reg_index_t [decode_width-1:0]     uop_rd,
  output frontend_pkg::reg_index_t [decode_width-1:0]     uop_rs1,
  output frontend_pkg::reg_index_t [decode_width-1:0]     uop_rs2,
  output logic [decode_width-1:0][frontend_pkg::xlen-1:0] uop_imm,
  output logic [decode_width-1:0]                         uop_rd_valid
);

  import frontend_pkg::*;

  op_class_t [decode_width-1:0]            dec_class;
  logic      [decode_width-1:0][xlen-1:0]  dec_imm;
  logic      [decode_width-1:0]            dec_rd_valid;

  // output register empty or being taken
  assign group_ready = !(|uop_valid) || uop_ready;

  always_comb begin
    logic [xlen-1:0] inst;
    logic            writes;
    for (int i = 0; i < decode_width; i++) begin
      inst = group_inst[i];
      case (inst[6:0])
        op_alu_reg: begin
          dec_class[i] = alu_reg;
          dec_imm[i]   = '0;
        end
        op_alu_imm: begin
          dec_class[i] = alu_imm;
          dec_imm[i]   = {{20{inst[31]}}, inst[31:20]};
        end
        op_load: begin
          dec_class[i] = load;
          dec_imm[i]   = {{20{inst[31]}}, inst[31:20]};
        end
        op_store: begin
          dec_class[i] = store;
          dec_imm[i]   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        end
        op_branch: begin
          dec_class[i] = branch;
          dec_imm[i]   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
        op_jal: begin
          dec_class[i] = jal;
          dec_imm[i]   = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        op_jalr: begin
          dec_class[i] = jalr;
          dec_imm[i]   = {{20{inst[31]}}, inst[31:20]};
        end
        op_lui: begin
          dec_class[i] = lui;
          dec_imm[i]   = {inst[31:12], 12'b0};
        end
        op_auipc: begin
          dec_class[i] = auipc;
          dec_imm[i]   = {inst[31:12], 12'b0};
        end
        op_system: begin
          dec_class[i] = system;
          dec_imm[i]   = '0;
        end
        default: begin
          dec_class[i] = illegal;
          dec_imm[i]   = '0;
        end
      endcase
      // x0 is never a real destination
      writes          = !(dec_class[i] inside {store, branch, illegal});
      dec_rd_valid[i] = writes && (inst[11:7] != 5'd0);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      uop_valid <= '0;
    end else if (group_ready) begin
      uop_valid <= group_valid;
    end
  end

  // micro-op payload
  always_ff @(posedge clock) begin
    if (group_ready) begin
      for (int i = 0; i < decode_width; i++) begin
        uop_pc[i]       <= group_pc[i];
        uop_class[i]    <= dec_class[i];
        uop_rd[i]       <= group_inst[i][11:7];
        uop_rs1[i]      <= group_inst[i][19:15];
        uop_rs2[i]      <= group_inst[i][24:20];
        uop_imm[i]      <= dec_imm[i];
        uop_rd_valid[i] <= dec_rd_valid[i];
      end
    end
  end

  uop_held: assert property (
    @(posedge clock) disable iff (reset)
    (|uop_valid) && !uop_ready |=>
      $stable(uop_valid) && $stable(uop_pc) && $stable(uop_class) &&
      $stable(uop_rd) && $stable(uop_rs1) && $stable(uop_rs2) &&
      $stable(uop_imm) && $stable(uop_rd_valid)
  ) else $error("micro-op group changed while stalled");

endmodule

`default_nettype wire

// ==== source/frontend.sv ====
// front end top
// fetch, fetch buffer and decode chained by valid/ready handshakes,
// from the instruction-cache line port to the micro-op outputs

`timescale 1ns/1ps
`default_nettype none

module frontend #(
  parameter int fetch_width  = frontend_pkg::line_bits / frontend_pkg::xlen,
  parameter int decode_width = 4,
  parameter int buffer_depth = 16,
  parameter logic [frontend_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                                            clock,
  input  logic                                            reset,
  input  logic [frontend_pkg::line_bits-1:0]              icache2core_data,
  input  logic                                            icache2core_data_valid,
  output logic [frontend_pkg::xlen-1:0]                   core2icache_addr,
  input  logic                                            uop_ready,
  output logic [decode_width-1:0]                         uop_valid,
  output logic [decode_width-1:0][frontend_pkg::xlen-1:0] uop_pc,
  output frontend_pkg::op_class_t [decode_width-1:0]      uop_class,
  output frontend_pkg::reg_index_t [decode_width-1:0]     uop_rd,
  output frontend_pkg::reg_index_t [decode_width-1:0]     uop_rs1,
  output frontend_pkg::reg_index_t [decode_width-1:0]     uop_rs2,
  output logic [decode_width-1:0][frontend_pkg::xlen-1:0] uop_imm,
  output logic [decode_width-1:0]                         uop_rd_valid
);

  import frontend_pkg::*;

  // fetch to buffer
  logic                 line_valid;
  logic                 line_ready;
  logic [xlen-1:0]      line_pc;
  logic [line_bits-1:0] line_data;

  // buffer to decode
  logic [decode_width-1:0]           group_valid;
  logic                              group_ready;
  logic [decode_width-1:0][xlen-1:0] group_pc;
  logic [decode_width-1:0][xlen-1:0] group_inst;

  inst_fetch #(
    .fetch_width (fetch_width),
    .reset_pc    (reset_pc)
  ) u_fetch (
    .clock                  (clock),
    .reset                  (reset),
    .icache2core_data       (icache2core_data),
    .icache2core_data_valid (icache2core_data_valid),
    .line_ready             (line_ready),
    .core2icache_addr       (core2icache_addr),
    .line_valid             (line_valid),
    .line_pc                (line_pc),
    .line_data              (line_data)
  );

  fetch_buffer #(
    .fetch_width  (fetch_width),
    .decode_width (decode_width),
    .buffer_depth (buffer_depth)
  ) u_buffer (
    .clock       (clock),
    .reset       (reset),
    .line_valid  (line_valid),
    .line_pc     (line_pc),
    .line_data   (line_data),
    .group_ready (group_ready),
    .line_ready  (line_ready),
    .group_valid (group_valid),
    .group_pc    (group_pc),
    .group_inst  (group_inst)
  );

  inst_decode #(
    .decode_width (decode_width)
  ) u_decode (
    .clock        (clock),
    .reset        (reset),
    .group_valid  (group_valid),
    .group_pc     (group_pc),
    .group_inst   (group_inst),
    .uop_ready    (uop_ready),
    .group_ready  (group_ready),
    .uop_valid    (uop_valid),
    .uop_pc       (uop_pc),
    .uop_class    (uop_class),
    .uop_rd       (uop_rd),
    .uop_rs1      (uop_rs1),
    .uop_rs2      (uop_rs2),
    .uop_imm      (uop_imm),
    .uop_rd_valid (uop_rd_valid)
  );

endmodule

`default_nettype wire

// ==== tests/frontend_tb.sv ====
// front end testbench
// random RV32I memory behind a variable-latency line cache, random
// back-pressure on the micro-op port, checks by concurrent assertions

`timescale 1ns/1ps
`default_nettype none

module frontend_tb;

  import frontend_pkg::*;

  localparam int              decode_width = 4;
  localparam int              buffer_depth = 16;
  localparam logic [xlen-1:0] reset_pc     = 32'h0000_0000;
  localparam int              run_length   = 600;
  localparam int              reset_cycles = 4;
  localparam int              mem_words    = 1024;
  localparam logic [6:0]      unused_op    = 7'b1111111;

  logic                              clock;
  logic                              reset;
  logic [line_bits-1:0]              icache2core_data;
  logic                              icache2core_data_valid;
  logic [xlen-1:0]                   core2icache_addr;
  logic                              uop_ready;
  logic [decode_width-1:0]           uop_valid;
  logic [decode_width-1:0][xlen-1:0] uop_pc;
  op_class_t [decode_width-1:0]      uop_class;
  reg_index_t [decode_width-1:0]     uop_rd;
  reg_index_t [decode_width-1:0]     uop_rs1;
  reg_index_t [decode_width-1:0]     uop_rs2;
  logic [decode_width-1:0][xlen-1:0] uop_imm;
  logic [decode_width-1:0]           uop_rd_valid;

  logic [xlen-1:0] mem [mem_words];
  logic [6:0]      legal_opcodes [10];
  integer          seed;
  int              cache_wait;
  logic [xlen-1:0] served_addr;

  // scoreboard state
  logic [xlen-1:0] next_pc;
  int              checked_count;
  logic            stall_q = 1'b0;
  logic            idle_q = 1'b0;
  logic [xlen-1:0] prev_addr;

  frontend #(
    .decode_width (decode_width),
    .buffer_depth (buffer_depth),
    .reset_pc     (reset_pc)
  ) dut (
    .clock                  (clock),
    .reset                  (reset),
    .icache2core_data       (icache2core_data),
    .icache2core_data_valid (icache2core_data_valid),
    .core2icache_addr       (core2icache_addr),
    .uop_ready              (uop_ready),
    .uop_valid              (uop_valid),
    .uop_pc                 (uop_pc),
    .uop_class              (uop_class),
    .uop_rd                 (uop_rd),
    .uop_rs1                (uop_rs1),
    .uop_rs2                (uop_rs2),
    .uop_imm                (uop_imm),
    .uop_rd_valid           (uop_rd_valid)
  );

  always #20 clock = ~clock;

  function automatic op_class_t expected_class(input logic [31:0] inst);
    case (inst[6:0])
      op_alu_reg: return alu_reg;
      op_alu_imm: return alu_imm;
      op_load:    return load;
      op_store:   return store;
      op_branch:  return branch;
      op_jal:     return jal;
      op_jalr:    return jalr;
      op_lui:     return lui;
      op_auipc:   return auipc;
      op_system:  return system;
      default:    return illegal;
    endcase
  endfunction

  // sign-extended immediate by instruction format
  function automatic logic [31:0] expected_imm(input logic [31:0] inst);
    logic signed [11:0] i_imm;
    logic signed [11:0] s_imm;
    logic signed [12:0] b_imm;
    logic signed [20:0] j_imm;
    logic signed [31:0] wide;
    i_imm = inst[31:20];
    s_imm = {inst[31:25], inst[11:7]};
    b_imm = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    j_imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    case (expected_class(inst))
      alu_imm, load, jalr: wide = i_imm;
      store:               wide = s_imm;
      branch:              wide = b_imm;
      jal:                 wide = j_imm;
      lui, auipc:          wide = {inst[31:12], 12'h000};
      default:             wide = '0;
    endcase
    return wide;
  endfunction

  function automatic logic expected_rd_valid(input logic [31:0] inst);
    case (expected_class(inst))
      store, branch, illegal: return 1'b0;
      default:                return inst[11:7] != 5'd0;
    endcase
  endfunction

  function automatic logic mask_is_contiguous(input logic [decode_width-1:0] mask);
    logic seen_gap;
    seen_gap = 1'b0;
    for (int k = 0; k < decode_width; k++) begin
      if (!mask[k]) begin
        seen_gap = 1'b1;
      end else if (seen_gap) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  function automatic logic [line_bits-1:0] line_at(input logic [xlen-1:0] addr);
    return {mem[addr[11:2] + 10'd3], mem[addr[11:2] + 10'd2],
            mem[addr[11:2] + 10'd1], mem[addr[11:2]]};
  endfunction

  task automatic report_mismatch(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
    $display("ERROR at %0d ns: %s expected %0h, actual %0h", $time, name, expected, actual);
    $display("*** TEST FAILED ***");
    $fatal(1, "value check on %s failed", name);
  endtask

  task automatic report_failure(input string what);
    $display("ERROR at %0d ns: %s", $time, what);
    $display("*** TEST FAILED ***");
    $fatal(1, "check failed");
  endtask

  // memory fill, reset, then cache and uop_ready driven each cycle
  initial begin
    logic [31:0] word;
    clock                  = 1'b0;
    reset                  = 1'b1;
    icache2core_data       = '0;
    icache2core_data_valid = 1'b0;
    uop_ready              = 1'b0;
    served_addr            = '0;
    seed                   = 32'hb4fa;
    legal_opcodes = '{op_alu_reg, op_alu_imm, op_load, op_store, op_branch,
                      op_jal, op_jalr, op_lui, op_auipc, op_system};
    for (int a = 0; a < mem_words; a++) begin
      word = $random(seed);
      if (a % 8 == 7) begin
        word[6:0] = unused_op;
      end else begin
        word[6:0] = legal_opcodes[$unsigned($random(seed)) % 10];
      end
      mem[a] = word;
    end
    repeat (reset_cycles) @(posedge clock);
    #2;
    reset      = 1'b0;
    cache_wait = $unsigned($random(seed)) % 4;
    forever begin
      // address moved, so the offered line was captured
      if (icache2core_data_valid && core2icache_addr != served_addr) begin
        icache2core_data_valid = 1'b0;
        cache_wait             = $unsigned($random(seed)) % 4;
      end
      if (!icache2core_data_valid) begin
        if (cache_wait == 0) begin
          served_addr            = core2icache_addr;
          icache2core_data       = line_at(core2icache_addr);
          icache2core_data_valid = 1'b1;
        end else begin
          cache_wait = cache_wait - 1;
        end
      end
      uop_ready = ($unsigned($random(seed)) % 3) != 0;
      @(posedge clock);
      #2;
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      next_pc       <= reset_pc;
      checked_count <= 0;
    end else if ((|uop_valid) && uop_ready) begin
      next_pc       <= next_pc + 32'(4 * $countones(uop_valid));
      checked_count <= checked_count + $countones(uop_valid);
    end
    stall_q   <= !reset && (|uop_valid) && !uop_ready;
    idle_q    <= !reset && !icache2core_data_valid;
    prev_addr <= core2icache_addr;
  end

  idle_after_reset: assert property (@(posedge clock) $fell(reset) |-> uop_valid == '0)
    else report_mismatch("uop_valid", '0, $sampled(uop_valid));

  addr_after_reset: assert property (@(posedge clock)
    $fell(reset) |-> core2icache_addr == reset_pc)
    else report_mismatch("core2icache_addr", reset_pc, $sampled(core2icache_addr));

  addr_aligned: assert property (@(posedge clock) disable iff (reset)
    core2icache_addr[3:0] == 4'h0)
    else report_failure($sformatf("fetch address %h is not a multiple of 16",
                                  $sampled(core2icache_addr)));

  addr_holds: assert property (@(posedge clock) disable iff (reset)
    idle_q |-> core2icache_addr == prev_addr)
    else report_mismatch("core2icache_addr", $sampled(prev_addr), $sampled(core2icache_addr));

  mask_contiguous: assert property (@(posedge clock) disable iff (reset)
    mask_is_contiguous(uop_valid))
    else report_failure($sformatf("uop_valid mask %b is not filled from slot 0",
                                  $sampled(uop_valid)));

  for (genvar i = 0; i < decode_width; i++) begin : slot
    logic        taken;
    logic [31:0] exp_inst;
    op_class_t   exp_class;
    logic [84:0] now_bits;
    logic [84:0] prev_bits;

    assign taken     = uop_valid[i] && uop_ready;
    assign exp_inst  = mem[uop_pc[i][11:2]];
    assign exp_class = expected_class(exp_inst);
    assign now_bits  = {uop_pc[i], uop_class[i], uop_rd[i], uop_rs1[i], uop_rs2[i],
                        uop_imm[i], uop_rd_valid[i], uop_valid[i]};

    always @(posedge clock) begin
      prev_bits <= now_bits;
    end

    pc_order: assert property (@(posedge clock) disable iff (reset)
      taken |-> uop_pc[i] == next_pc + 32'(4 * i))
      else report_mismatch($sformatf("uop_pc[%0d]", i), $sampled(next_pc) + 32'(4 * i),
                           $sampled(uop_pc[i]));

    class_ok: assert property (@(posedge clock) disable iff (reset)
      taken |-> uop_class[i] == exp_class)
      else report_mismatch($sformatf("uop_class[%0d]", i), $sampled(exp_class),
                           $sampled(uop_class[i]));

    rd_ok: assert property (@(posedge clock) disable iff (reset)
      taken |-> uop_rd[i] == exp_inst[11:7])
      else report_mismatch($sformatf("uop_rd[%0d]", i), $sampled(exp_inst[11:7]),
                           $sampled(uop_rd[i]));

    rs1_ok: assert property (@(posedge clock) disable iff (reset)
      taken |-> uop_rs1[i] == exp_inst[19:15])
      else report_mismatch($sformatf("uop_rs1[%0d]", i), $sampled(exp_inst[19:15]),
                           $sampled(uop_rs1[i]));

    rs2_ok: assert property (@(posedge clock) disable iff (reset)
      taken |-> uop_rs2[i] == exp_inst[24:20])
      else report_mismatch($sformatf("uop_rs2[%0d]", i), $sampled(exp_inst[24:20]),
                           $sampled(uop_rs2[i]));

    imm_ok: assert property (@(posedge clock) disable iff (reset)
      taken |-> uop_imm[i] == expected_imm(exp_inst))
      else report_mismatch($sformatf("uop_imm[%0d]", i), expected_imm($sampled(exp_inst)),
                           $sampled(uop_imm[i]));

    rd_valid_ok: assert property (@(posedge clock) disable iff (reset)
      taken |-> uop_rd_valid[i] == expected_rd_valid(exp_inst))
      else report_mismatch($sformatf("uop_rd_valid[%0d]", i),
                           expected_rd_valid($sampled(exp_inst)), $sampled(uop_rd_valid[i]));

    // store, branch and illegal never write whatever rd holds
    no_write: assert property (@(posedge clock) disable iff (reset)
      uop_valid[i] && (uop_class[i] == store || uop_class[i] == branch ||
                       uop_class[i] == illegal) |-> !uop_rd_valid[i])
      else report_mismatch($sformatf("uop_rd_valid[%0d]", i), 1'b0, $sampled(uop_rd_valid[i]));

    held: assert property (@(posedge clock) disable iff (reset)
      stall_q |-> now_bits == prev_bits)
      else report_mismatch($sformatf("uop slot %0d outputs", i), $sampled(prev_bits),
                           $sampled(now_bits));
  end

  initial begin
    wait (checked_count >= run_length);
    #1;
    $display("%0d micro-operations checked", checked_count);
    $display("*** TEST PASSED ***");
    $finish;
  end

  initial begin
    repeat (reset_cycles + run_length * 8) @(posedge clock);
    $display("watchdog expired: the pipeline stopped delivering, %0d of %0d checked",
             checked_count, run_length);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire

// ==== sources.f ====
source/frontend_pkg.sv
source/inst_fetch.sv
source/fetch_buffer.sv
source/inst_decode.sv
source/frontend.sv
tests/frontend_tb.sv

// ==== Bender.yml ====
package:
  name: frontend

dependencies: {}

sources:
  - source/frontend_pkg.sv
  - source/inst_fetch.sv
  - source/fetch_buffer.sv
  - source/inst_decode.sv
  - source/frontend.sv
  - target: test
    files:
      - tests/frontend_tb.sv
